// ==== videoTxUnit.f ====
src/videoTimingPkg.sv
src/videoPixelPkg.sv
src/videoPixelGen.sv
src/videoLineFifo.sv
src/videoSyncGen.sv
src/videoTftOut.sv
src/videoBacklightPwm.sv
src/videoTxUnit.sv
test/tbVideoTxUnit.sv

// ==== Bender.yml ====
package:
  name: videoTxUnit

sources:
  # Packages first
  - src/videoTimingPkg.sv
  - src/videoPixelPkg.sv
  # Design
  - src/videoPixelGen.sv
  - src/videoLineFifo.sv
  - src/videoSyncGen.sv
  - src/videoTftOut.sv
  - src/videoBacklightPwm.sv
  - src/videoTxUnit.sv
  # Testbench
  - target: test
    files:
      - test/tbVideoTxUnit.sv

// ==== test/tbVideoTxUnit.sv ====
/*
 * Testbench for the TFT video transmitter top.
 * Applies a table of timing and pattern settings, each after its own reset,
 * and compares sync, color, underrun and backlight with a cycle model
 * built from the counter, window and latency rules of the design.
 */

`timescale 1ns/1ps

module tbVideoTxUnit
	import videoTimingPkg::*, videoPixelPkg::*;
();

	localparam int lpRows        = 4;
	localparam int lpResetCycles = 8;

	// One stimulus row, with per-frame counts worked out by hand
	typedef struct packed {
		videoTimingT timing;
		patternSelT  patternSel;
		pixelArgbT   fillColor;
		logic [7:0]  blDutyRatio;
		logic [15:0] expDe;
		logic [15:0] expHSync;
		logic [15:0] expVSync;
	} stimRowT;

	logic        iVideoClk;
	logic        rst;
	videoTimingT timing;
	patternSelT  patternSel;
	pixelArgbT   fillColor;
	logic [7:0]  blDutyRatio;
	tftColorT    tftColor;
	videoSyncT   tftSync;
	logic        tftBackLight;
	logic        underrun;

	stimRowT     rows [lpRows];
	logic [31:0] lfsrState;
	int          syncErrs;
	int          colorErrs;
	int          otherErrs;
	int          cycleCnt = 0;
	int          timeoutLimit = 0;

	videoTxUnit #(
		.pTimingWidth (12),
		.pFifoDepth   (16)
	) u_videoTxUnit (
		.iVideoClk    (iVideoClk),
		.rst          (rst),
		.timing       (timing),
		.patternSel   (patternSel),
		.fillColor    (fillColor),
		.blDutyRatio  (blDutyRatio),
		.tftColor     (tftColor),
		.tftSync      (tftSync),
		.tftBackLight (tftBackLight),
		.underrun     (underrun)
	);

	// 25 MHz pixel clock
	initial
	begin
		iVideoClk = 1'b0;
		forever #20 iVideoClk = ~iVideoClk;
	end

	// --------------------
	// Helpers
	// --------------------

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic videoTimingT makeTiming(input int hD, input int hSS, input int hSE,
		input int hM, input int vD, input int vSS, input int vSE, input int vM);
		videoTimingT tm;
		tm.hDisplay   = hD[11:0];
		tm.hSyncStart = hSS[11:0];
		tm.hSyncEnd   = hSE[11:0];
		tm.hMax       = hM[11:0];
		tm.vDisplay   = vD[11:0];
		tm.vSyncStart = vSS[11:0];
		tm.vSyncEnd   = vSE[11:0];
		tm.vMax       = vM[11:0];
		return tm;
	endfunction

	task automatic setRow(input int idx, input videoTimingT tm, input patternSelT pat,
		input pixelArgbT fill, input logic [7:0] duty, input int de, input int hs, input int vs);
		rows[idx].timing      = tm;
		rows[idx].patternSel  = pat;
		rows[idx].fillColor   = fill;
		rows[idx].blDutyRatio = duty;
		rows[idx].expDe       = de[15:0];
		rows[idx].expHSync    = hs[15:0];
		rows[idx].expVSync    = vs[15:0];
	endtask

	function automatic int frameCycles(input videoTimingT tm);
		return (tm.hMax + 1) * (tm.vMax + 1);
	endfunction

	// Two frames plus one full PWM period
	function automatic int rowCycles(input videoTimingT tm);
		return 2 * frameCycles(tm) + 256;
	endfunction

	// Panel sync t cycles after release, counters two clocks behind
	function automatic videoSyncT expectSync(input videoTimingT tm, input int t);
		int        n;
		int        h;
		int        v;
		videoSyncT s;
		s = '0;
		if (t >= 2)
		begin
			n       = t - 2;
			h       = n % (tm.hMax + 1);
			v       = (n / (tm.hMax + 1)) % (tm.vMax + 1);
			s.hSync = (h >= tm.hSyncStart) && (h < tm.hSyncEnd);
			s.vSync = (v >= tm.vSyncStart) && (v < tm.vSyncEnd);
			s.de    = (h < tm.hDisplay) && (v < tm.vDisplay);
		end
		return s;
	endfunction

	// Color of the deIdx-th visible pixel since reset
	function automatic tftColorT expectColor(input stimRowT r, input int deIdx);
		int       x;
		int       y;
		int       f;
		tftColorT c;
		x = deIdx % r.timing.hDisplay;
		y = (deIdx / r.timing.hDisplay) % r.timing.vDisplay;
		f = deIdx / (r.timing.hDisplay * r.timing.vDisplay);
		if (r.patternSel == patGradient)
		begin
			c.red   = x[3:0];
			c.green = y[3:0];
			c.blue  = f[3:0];
		end
		else if (r.fillColor.alpha == 4'h0)
			c = '0;
		else
		begin
			c.red   = r.fillColor.red;
			c.green = r.fillColor.green;
			c.blue  = r.fillColor.blue;
		end
		return c;
	endfunction

	// --------------------
	// One table row
	// --------------------

	task automatic runRow(input int r);
		int        rowLen;
		int        frameLen;
		int        deIdx;
		int        deCnt;
		int        hsCnt;
		int        vsCnt;
		int        blSum;
		logic      blHist [256];
		videoSyncT expSync;
		tftColorT  expColor;
		frameLen = frameCycles(rows[r].timing);
		rowLen   = rowCycles(rows[r].timing);
		deIdx    = 0;
		deCnt    = 0;
		hsCnt    = 0;
		vsCnt    = 0;
		blSum    = 0;
		for (int i = 0; i < 256; i++)
			blHist[i] = 1'b0;
		// Settings change only under reset
		@(negedge iVideoClk);
		rst         = 1'b1;
		timing      = rows[r].timing;
		patternSel  = rows[r].patternSel;
		fillColor   = rows[r].fillColor;
		blDutyRatio = rows[r].blDutyRatio;
		repeat (lpResetCycles) @(negedge iVideoClk);
		rst = 1'b0;
		assert (tftColor == '0 && tftSync == '0 && !tftBackLight && !underrun)
		else
		begin
			otherErrs++;
			$display("error at %0t: outputs not cleared after reset, row %0d", $time, r);
		end
		for (int t = 1; t <= rowLen; t++)
		begin
			@(negedge iVideoClk);
			expSync = expectSync(rows[r].timing, t);
			if (expSync.de)
			begin
				expColor = expectColor(rows[r], deIdx);
				deIdx++;
			end
			else
				expColor = '0;
			assert (tftSync == expSync)
			else
			begin
				syncErrs++;
				$display("error at %0t: tftSync %b, expected %b (row %0d, cycle %0d)",
					$time, tftSync, expSync, r, t);
			end
			assert (tftColor == expColor)
			else
			begin
				colorErrs++;
				$display("error at %0t: tftColor %h, expected %h (row %0d, pixel %0d)",
					$time, tftColor, expColor, r, deIdx - 1);
			end
			assert (!underrun)
			else
			begin
				otherErrs++;
				$display("error at %0t: underrun set (row %0d, cycle %0d)", $time, r, t);
			end
			// First frame, from count (0,0)
			if (t >= 2 && t < 2 + frameLen)
			begin
				deCnt += int'(tftSync.de);
				hsCnt += int'(tftSync.hSync);
				vsCnt += int'(tftSync.vSync);
			end
			if (t == 1 + frameLen)
			begin
				assert (deCnt == rows[r].expDe && hsCnt == rows[r].expHSync &&
					vsCnt == rows[r].expVSync)
				else
				begin
					syncErrs++;
					$display("error at %0t: frame counts de %0d hs %0d vs %0d, row %0d",
						$time, deCnt, hsCnt, vsCnt, r);
				end
			end
			// Sliding 256-cycle window on the backlight
			blSum += int'(tftBackLight);
			blSum -= int'(blHist[t % 256]);
			blHist[t % 256] = tftBackLight;
			if (t >= 256)
			begin
				assert (blSum == rows[r].blDutyRatio)
				else
				begin
					otherErrs++;
					$display("error at %0t: backlight high %0d of 256, expected %0d",
						$time, blSum, rows[r].blDutyRatio);
				end
			end
		end
	endtask

	// --------------------
	// Watchdog
	// --------------------

	always @(posedge iVideoClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (timeoutLimit > 0 && cycleCnt >= timeoutLimit)
		begin
			$display("Timeout: the run did not finish within %0d clock cycles", timeoutLimit);
			$display("Done: errors found");
			$finish;
		end
	end

	// --------------------
	// Main sequence
	// --------------------

	initial
	begin
		pixelArgbT lfsrColor;
		int        totalLen;
		rst         = 1'b1;
		timing      = '0;
		patternSel  = patGradient;
		fillColor   = '0;
		blDutyRatio = '0;
		syncErrs    = 0;
		colorErrs   = 0;
		otherErrs   = 0;
		lfsrState   = 32'h61b4_39e1;
		// One LFSR step per color bit
		for (int b = 0; b < 16; b++)
		begin
			lfsrState    = lfsrNext(lfsrState);
			lfsrColor[b] = lfsrState[0];
		end
		// Small gradient, then one wider than 16 pixels and lines
		setRow(0, makeTiming(8, 9, 11, 13, 4, 4, 5, 6), patGradient, 16'h5A3C, 8'd64,
			32, 14, 14);
		setRow(1, makeTiming(20, 22, 25, 27, 18, 19, 21, 22), patGradient, 16'hFFFF, 8'd0,
			360, 69, 56);
		setRow(2, makeTiming(6, 7, 8, 10, 5, 6, 8, 8), patFill, lfsrColor, 8'd255,
			30, 9, 22);
		// Transparent fill shows black
		setRow(3, makeTiming(4, 5, 7, 8, 3, 3, 4, 5), patFill, 16'h0ABC, 8'd129,
			12, 12, 9);
		totalLen = 0;
		for (int r = 0; r < lpRows; r++)
			totalLen += rowCycles(rows[r].timing) + lpResetCycles;
		timeoutLimit = totalLen * 3 / 2;
		for (int r = 0; r < lpRows; r++)
			runRow(r);
		$display("Errors: sync %0d, color %0d, other %0d", syncErrs, colorErrs, otherErrs);
		if (syncErrs + colorErrs + otherErrs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== src/videoTxUnit.sv ====
/*
 * Video transmitter top for a TFT panel.
 * Pattern producer -> line FIFO -> output stage, paced by the sync
 * generator, plus backlight PWM. One clock, one synchronous reset.
 * Settings must only change while rst is high.
 */

`timescale 1ns/1ps

module videoTxUnit
	import videoTimingPkg::*, videoPixelPkg::*;
#(
	parameter int pTimingWidth = 12,
	parameter int pFifoDepth   = 16
)(
	input  logic        iVideoClk,
	input  logic        rst,
	input  videoTimingT timing,
	input  patternSelT  patternSel,
	input  pixelArgbT   fillColor,
	input  logic [7:0]  blDutyRatio,
	output tftColorT    tftColor,
	output videoSyncT   tftSync,
	output logic        tftBackLight,
	output logic        underrun
);

	// Producer to FIFO
	pixelArgbT genPixel;
	logic      push;
	logic      full;
	// FIFO to output stage
	pixelArgbT rdPixel;
	logic      pop;
	logic      empty;
	// Raw timing, one cycle ahead of the panel
	videoSyncT sync;

	// --------------------
	// Pixel path
	// --------------------

	videoPixelGen #(
		.pTimingWidth (pTimingWidth)
	) u_pixelGen (
		.iVideoClk  (iVideoClk),
		.rst        (rst),
		.timing     (timing),
		.patternSel (patternSel),
		.fillColor  (fillColor),
		.full       (full),
		.pixel      (genPixel),
		.push       (push)
	);

	videoLineFifo #(
		.pFifoDepth (pFifoDepth)
	) u_lineFifo (
		.iVideoClk (iVideoClk),
		.rst       (rst),
		.push      (push),
		.wrPixel   (genPixel),
		.full      (full),
		.pop       (pop),
		.rdPixel   (rdPixel),
		.empty     (empty)
	);

	// --------------------
	// Timing and output
	// --------------------

	videoSyncGen #(
		.pTimingWidth (pTimingWidth)
	) u_syncGen (
		.iVideoClk (iVideoClk),
		.rst       (rst),
		.timing    (timing),
		.sync      (sync)
	);

	// Two clocks from counter state to panel pins
	videoTftOut u_tftOut (
		.iVideoClk (iVideoClk),
		.rst       (rst),
		.sync      (sync),
		.empty     (empty),
		.rdPixel   (rdPixel),
		.pop       (pop),
		.tftSync   (tftSync),
		.tftColor  (tftColor),
		.underrun  (underrun)
	);

	// Backlight dimming
	videoBacklightPwm u_backlightPwm (
		.iVideoClk (iVideoClk),
		.rst       (rst),
		.dutyRatio (blDutyRatio),
		.pwm       (tftBackLight)
	);

endmodule

// ==== src/videoBacklightPwm.sv ====
/*
 * Backlight dimming PWM.
 * High for dutyRatio clocks out of every 256.
 */

`timescale 1ns/1ps

module videoBacklightPwm (
	input  logic       iVideoClk,
	input  logic       rst,
	input  logic [7:0] dutyRatio,
	output logic       pwm
);

	// Free-running period counter
	logic [7:0] periodCnt;

	always_ff @(posedge iVideoClk)
	begin
		if (rst)
			periodCnt <= '0;
		else
			periodCnt <= periodCnt + 8'd1;
	end

	// Registered compare, 0 keeps the light off
	always_ff @(posedge iVideoClk)
	begin
		if (rst)
			pwm <= 1'b0;
		else
			pwm <= (periodCnt < dutyRatio);
	end

endmodule

// ==== src/videoTftOut.sv ====
/*
 * Panel output stage.
 * Pops one pixel per active clock and delays the sync bundle by one
 * cycle so it lines up with the FIFO read data. Transparent pixels
 * show as black. A pop on an empty FIFO sets a sticky underrun flag.
 */

`timescale 1ns/1ps

module videoTftOut
	import videoTimingPkg::*, videoPixelPkg::*;
(
	input  logic      iVideoClk,
	input  logic      rst,
	input  videoSyncT sync,
	input  logic      empty,
	input  pixelArgbT rdPixel,
	output logic      pop,
	output videoSyncT tftSync,
	output tftColorT  tftColor,
	output logic      underrun
);

	// Pixel is shown only when opaque enough to be seen
	logic visible;

	// One read request per active clock
	assign pop = sync.de;

	// --------------------
	// Sync alignment
	// --------------------

	// Matches the one-cycle FIFO read latency
	always_ff @(posedge iVideoClk)
	begin
		if (rst)
			tftSync <= '0;
		else
			tftSync <= sync;
	end

	// --------------------
	// Color
	// --------------------

	// Alpha 0 means transparent over black
	assign visible = tftSync.de && (rdPixel.alpha != 4'h0);

	always_comb
	begin
		if (visible)
		begin
			tftColor.red   = rdPixel.red;
			tftColor.green = rdPixel.green;
			tftColor.blue  = rdPixel.blue;
		end
		else
			tftColor = '0;
	end

	// --------------------
	// Underrun
	// --------------------

	// Sticky, only reset clears it
	always_ff @(posedge iVideoClk)
	begin
		if (rst)
			underrun <= 1'b0;
		else if (sync.de && empty)
			underrun <= 1'b1;
	end

endmodule

// ==== src/videoSyncGen.sv ====
/*
 * Display timing generator.
 * Free-running horizontal and vertical counters compared with the
 * run-time timing settings. HSync, VSync and de are registered,
 * one clock behind the counter state that produced them.
 */

`timescale 1ns/1ps

module videoSyncGen
	import videoTimingPkg::*;
#(
	parameter int pTimingWidth = 12
)(
	input  logic        iVideoClk,
	input  logic        rst,
	input  videoTimingT timing,
	output videoSyncT   sync
);

	// Pixel within line, line within frame
	logic [pTimingWidth-1:0] hCnt;
	logic [pTimingWidth-1:0] vCnt;
	logic                    hWrap;
	logic                    vWrap;

	// Decoded from the current count
	logic                    hSyncNext;
	logic                    vSyncNext;
	logic                    deNext;

	assign hWrap = (hCnt == timing.hMax);
	assign vWrap = (vCnt == timing.vMax);

	// --------------------
	// Counters
	// --------------------

	always_ff @(posedge iVideoClk)
	begin
		if (rst)
		begin
			hCnt <= '0;
			vCnt <= '0;
		end
		else if (hWrap)
		begin
			hCnt <= '0;
			// Next line, or top of next frame
			if (vWrap)
				vCnt <= '0;
			else
				vCnt <= vCnt + 1'b1;
		end
		else
			hCnt <= hCnt + 1'b1;
	end

	// --------------------
	// Decode
	// --------------------

	always_comb
	begin
		// Pulse windows are [start, end)
		hSyncNext = (hCnt >= timing.hSyncStart) && (hCnt < timing.hSyncEnd);
		vSyncNext = (vCnt >= timing.vSyncStart) && (vCnt < timing.vSyncEnd);
		// Visible area in both directions
		deNext    = (hCnt < timing.hDisplay) && (vCnt < timing.vDisplay);
	end

	// Output register
	always_ff @(posedge iVideoClk)
	begin
		if (rst)
			sync <= '0;
		else
		begin
			sync.hSync <= hSyncNext;
			sync.vSync <= vSyncNext;
			sync.de    <= deNext;
		end
	end

endmodule

// ==== src/videoLineFifo.sv ====
/*
 * Single-clock pixel FIFO between producer and output stage.
 * Push is ignored when full and pop when empty.
 * Read data is registered and valid one cycle after a pop.
 */

`timescale 1ns/1ps

module videoLineFifo
	import videoPixelPkg::*;
#(
	parameter int pFifoDepth = 16
)(
	input  logic      iVideoClk,
	input  logic      rst,
	input  logic      push,
	input  pixelArgbT wrPixel,
	output logic      full,
	input  logic      pop,
	output pixelArgbT rdPixel,
	output logic      empty
);

	localparam int lpAdrsWidth = $clog2(pFifoDepth);

	// Storage
	pixelArgbT mem [pFifoDepth];

	// Extra MSB tells a full ring from an empty one
	logic [lpAdrsWidth:0] wrPtr;
	logic [lpAdrsWidth:0] rdPtr;
	logic                 wrEn;
	logic                 rdEn;

	// Accepted transfers only
	assign wrEn = push & ~full;
	assign rdEn = pop & ~empty;

	// --------------------
	// Flags
	// --------------------

	// Same address, MSB differs -> wrapped once
	assign full  = (wrPtr[lpAdrsWidth] != rdPtr[lpAdrsWidth]) &&
		(wrPtr[lpAdrsWidth-1:0] == rdPtr[lpAdrsWidth-1:0]);
	assign empty = (wrPtr == rdPtr);

	// --------------------
	// Pointers
	// --------------------

	always_ff @(posedge iVideoClk)
	begin
		if (rst)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	// Write port
	always_ff @(posedge iVideoClk)
	begin
		if (wrEn)
			mem[wrPtr[lpAdrsWidth-1:0]] <= wrPixel;
	end

	// Registered read port, holds last value between pops
	always_ff @(posedge iVideoClk)
	begin
		if (rdEn)
			rdPixel <= mem[rdPtr[lpAdrsWidth-1:0]];
	end

endmodule

// ==== src/videoPixelGen.sv ====
/*
 * Test image producer.
 * Walks the visible frame in raster order and offers one pixel
 * per clock to the line FIFO, stalling while the FIFO is full.
 */

`timescale 1ns/1ps

module videoPixelGen
	import videoTimingPkg::*, videoPixelPkg::*;
#(
	parameter int pTimingWidth = 12
)(
	input  logic        iVideoClk,
	input  logic        rst,
	input  videoTimingT timing,
	input  patternSelT  patternSel,
	input  pixelArgbT   fillColor,
	input  logic        full,
	output pixelArgbT   pixel,
	output logic        push
);

	// Raster position of the pixel on offer
	logic [pTimingWidth-1:0] xPos;
	logic [pTimingWidth-1:0] yPos;
	// Only 16 frames matter for the blue channel
	logic [3:0]              frameCnt;
	logic                    lastX;
	logic                    lastY;

	// Offer every cycle there is room
	assign push = ~full;

	// End of line / end of frame
	assign lastX = (xPos == timing.hDisplay - 12'd1);
	assign lastY = (yPos == timing.vDisplay - 12'd1);

	// --------------------
	// Position counters
	// --------------------

	always_ff @(posedge iVideoClk)
	begin
		if (rst)
		begin
			xPos     <= '0;
			yPos     <= '0;
			frameCnt <= '0;
		end
		// Hold position while stalled
		else if (push)
		begin
			if (lastX)
			begin
				xPos <= '0;
				if (lastY)
				begin
					yPos     <= '0;
					frameCnt <= frameCnt + 4'd1;
				end
				else
					yPos <= yPos + 1'b1;
			end
			else
				xPos <= xPos + 1'b1;
		end
	end

	// --------------------
	// Pattern
	// --------------------

	// Pixel follows the held position, so it is stable under stall
	always_comb
	begin
		if (patternSel == patFill)
			pixel = fillColor;
		else
		begin
			// Opaque ramp, x on red, y on green, frame on blue
			pixel.alpha = 4'hF;
			pixel.red   = xPos[3:0];
			pixel.green = yPos[3:0];
			pixel.blue  = frameCnt;
		end
	end

endmodule

// ==== src/videoPixelPkg.sv ====
/*
 * Pixel formats for the TFT transmitter.
 * ARGB4444 travels from the pattern source through the line FIFO,
 * RGB444 leaves toward the panel. Also holds the pattern select.
 */

package videoPixelPkg;

	// Internal pixel, alpha in the top nibble
	typedef struct packed {
		logic [3:0] alpha;
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} pixelArgbT;

	// Panel side color, 4 bits per channel
	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} tftColorT;

	// Built-in test image choice
	typedef enum logic {
		patGradient,
		patFill
	} patternSelT;

endpackage

// ==== src/videoTimingPkg.sv ====
/*
 * Display timing types for the TFT transmitter.
 * Holds the run-time timing settings and the sync bundle
 * shared by the sync generator, pixel producer and output stage.
 */

package videoTimingPkg;

	// --------------------
	// Run-time timing
	// --------------------

	// All counts in pixel clocks (h) or lines (v)
	typedef struct packed {
		// Horizontal
		logic [11:0] hDisplay;
		logic [11:0] hSyncStart;
		logic [11:0] hSyncEnd;
		logic [11:0] hMax;
		// Vertical
		logic [11:0] vDisplay;
		logic [11:0] vSyncStart;
		logic [11:0] vSyncEnd;
		logic [11:0] vMax;
	} videoTimingT;

	// --------------------
	// Sync bundle
	// --------------------

	// Active high, de doubles as the pixel request
	typedef struct packed {
		logic hSync;
		logic vSync;
		logic de;
	} videoSyncT;

endpackage
